/* files.f */
timer_pkg.sv
timer_bus.sv
timer_regs.sv
timer_prescaler.sv
timer_counter.sv
timer_top.sv
tb_clock_gen.sv
timer_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run with verilator, the log decides pass or fail
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/1ps --top-module timer_tb \
    -f files.f -o timer_sim > build.log 2>&1 \
    && ./obj_dir/timer_sim > sim.log 2>&1 \
    || { cat build.log; echo "build or simulation did not complete"; exit 1; }
cat sim.log
grep -qF '*** TEST FAILED ***' sim.log && exit 1 || exit 0

/* tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int HALF_PERIOD  = 10,
    parameter int RESET_CYCLES = 10
) (
    output logic o_clk,
    output logic o_reset
);

    initial begin
        o_clk = 1'b0;
        forever begin
            #(HALF_PERIOD) o_clk = ~o_clk;
        end
    end

    // reset spans a fixed number of rising edges, released on a falling edge
    initial begin
        o_reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge o_clk);
        @(negedge o_clk);
        o_reset = 1'b0;
    end

endmodule

/* timer_bus.sv */
`timescale 1ns/1ps

module timer_bus #(
    parameter int NUM_CHANNELS = 2,
    parameter int CH_W         = (NUM_CHANNELS > 1) ? $clog2(NUM_CHANNELS) : 1
) (
    input  logic                          i_cs,
    input  logic                          i_rwb,
    input  logic [CH_W+1:0]               i_addr,
    input  logic [timer_pkg::DATA_W-1:0]  i_data,
    output timer_pkg::bus_req_t           o_req [NUM_CHANNELS],
    input  logic [timer_pkg::DATA_W-1:0]  i_rdata [NUM_CHANNELS],
    input  logic [NUM_CHANNELS-1:0]       i_irq_pending,
    output logic [timer_pkg::DATA_W-1:0]  o_data,
    output logic                          o_irqb
);

    logic [CH_W-1:0]      chan;
    timer_pkg::reg_addr_e offset;

    // upper address bits pick the channel, low two bits the register
    assign chan   = i_addr[CH_W+1:2];
    assign offset = timer_pkg::reg_addr_e'(i_addr[1:0]);

    // fan the bus out, only the addressed channel sees sel
    always_comb begin
        for (int i = 0; i < NUM_CHANNELS; i++) begin
            o_req[i].sel    = i_cs && (chan == CH_W'(i));
            o_req[i].rwb    = i_rwb;
            o_req[i].offset = offset;
            o_req[i].wdata  = i_data;
        end
    end

    // read data follows the address with no latency
    // unused channel codes read as zero
    always_comb begin
        o_data = '0;
        for (int i = 0; i < NUM_CHANNELS; i++) begin
            if (chan == CH_W'(i)) begin
                o_data = i_rdata[i];
            end
        end
    end

    // shared interrupt line, low while any channel is pending
    assign o_irqb = ~|i_irq_pending;

endmodule

/* timer_counter.sv */
`timescale 1ns/1ps

module timer_counter (
    input  logic                  clk,
    input  logic                  reset,
    input  timer_pkg::chan_cfg_t  i_cfg,
    input  logic                  i_tick,
    output timer_pkg::chan_stat_t o_stat
);

    logic [15:0] count;
    logic        hit;

    assign hit = (count == i_cfg.latch);

    always_ff @(posedge clk) begin
        if (reset) begin
            count <= '0;
        end else if (i_cfg.start) begin
            count <= '0;
        end else if (i_tick) begin
            if (hit) begin
                // one-shot holds at the latch value, repeat wraps
                if (!i_cfg.oneshot) begin
                    count <= '0;
                end
            end else begin
                count <= count + 16'd1;
            end
        end
    end

    // match lasts only the tick cycle that reaches the latch
    always_comb begin
        o_stat.count = count;
        o_stat.match = i_tick && hit;
    end

endmodule

/* timer_pkg.sv */
package timer_pkg;

    // width of the processor data bus
    localparam int DATA_W = 8;

    // register offsets within one channel
    typedef enum logic [1:0] {
        // counter low on read, latch low on write
        REG_LO        = 2'd0,
        // counter high on read, latch high on write
        REG_HI        = 2'd1,
        REG_DIV       = 2'd2,
        // status on read, control on write
        REG_CTRL_STAT = 2'd3
    } reg_addr_e;

    // control byte, upper bits kept as written
    typedef struct packed {
        logic [5:0] reserved;
        logic       oneshot;
        logic       irq_en;
    } ctrl_t;

    typedef struct packed {
        logic [5:0] zero;
        logic       irq_pending;
        logic       running;
    } status_t;

    // one channel's view of the processor bus
    typedef struct packed {
        logic              sel;
        logic              rwb;
        reg_addr_e         offset;
        logic [DATA_W-1:0] wdata;
    } bus_req_t;

    // channel settings from the register block to the datapath
    typedef struct packed {
        logic        start;
        logic        running;
        logic [15:0] latch;
        logic [7:0]  divisor;
        logic        oneshot;
    } chan_cfg_t;

    // counter state back to the register block
    typedef struct packed {
        logic [15:0] count;
        logic        match;
    } chan_stat_t;

endpackage

/* timer_prescaler.sv */
`timescale 1ns/1ps

module timer_prescaler #(
    parameter int PRESCALE_BITS = 8
) (
    input  logic                 clk,
    input  logic                 reset,
    input  timer_pkg::chan_cfg_t i_cfg,
    output logic                 o_tick
);

    localparam int PW = 8 + PRESCALE_BITS;

    logic [PW-1:0] pre_count;
    logic          terminal;

    // upper byte is compared with the divisor and lower bits run a full cycle
    assign terminal = (pre_count[PW-1:PRESCALE_BITS] == i_cfg.divisor)
                   && (&pre_count[PRESCALE_BITS-1:0]);

    assign o_tick = i_cfg.running && !i_cfg.start && terminal;

    always_ff @(posedge clk) begin
        if (reset) begin
            pre_count <= '0;
        end else if (i_cfg.start || !i_cfg.running || o_tick) begin
            pre_count <= '0;
        end else begin
            pre_count <= pre_count + PW'(1);
        end
    end

endmodule

/* timer_regs.sv */
`timescale 1ns/1ps

module timer_regs (
    input  logic                          clk,
    input  logic                          reset,
    input  timer_pkg::bus_req_t           i_req,
    input  timer_pkg::chan_stat_t         i_stat,
    output timer_pkg::chan_cfg_t          o_cfg,
    output logic [timer_pkg::DATA_W-1:0]  o_rdata,
    output logic                          o_irq_pending
);

    logic [15:0]         latch;
    logic [7:0]          divisor;
    timer_pkg::ctrl_t    ctrl;
    timer_pkg::status_t  status;
    logic                running;
    logic                irq_pending;
    logic                wr;
    logic                stat_rd;
    logic                start;

    assign wr      = i_req.sel && !i_req.rwb;
    assign stat_rd = i_req.sel && i_req.rwb && (i_req.offset == timer_pkg::REG_CTRL_STAT);

    // a latch low write restarts prescaler and counter at the same edge
    assign start = wr && (i_req.offset == timer_pkg::REG_LO);

    always_ff @(posedge clk) begin
        if (reset) begin
            latch       <= '1;
            divisor     <= '0;
            ctrl        <= '0;
            running     <= 1'b0;
            irq_pending <= 1'b0;
        end else begin
            // one-shot stops on its match, a new start below overrides
            if (i_stat.match && ctrl.oneshot) begin
                running <= 1'b0;
            end

            if (wr) begin
                unique case (i_req.offset)
                    timer_pkg::REG_LO: begin
                        latch[7:0] <= i_req.wdata;
                        running    <= 1'b1;
                    end
                    timer_pkg::REG_HI: begin
                        latch[15:8] <= i_req.wdata;
                    end
                    timer_pkg::REG_DIV: begin
                        divisor <= i_req.wdata;
                    end
                    timer_pkg::REG_CTRL_STAT: begin
                        ctrl <= timer_pkg::ctrl_t'(i_req.wdata);
                    end
                endcase
            end

            // a new match beats a clearing status read on the same edge
            if (stat_rd) begin
                irq_pending <= 1'b0;
            end
            if (i_stat.match && ctrl.irq_en) begin
                irq_pending <= 1'b1;
            end
        end
    end

    always_comb begin
        status             = '0;
        status.running     = running;
        status.irq_pending = irq_pending;
    end

    always_comb begin
        unique case (i_req.offset)
            timer_pkg::REG_LO:        o_rdata = i_stat.count[7:0];
            timer_pkg::REG_HI:        o_rdata = i_stat.count[15:8];
            timer_pkg::REG_DIV:       o_rdata = divisor;
            timer_pkg::REG_CTRL_STAT: o_rdata = status;
            default:                  o_rdata = '0;
        endcase
    end

    always_comb begin
        o_cfg.start   = start;
        o_cfg.running = running;
        o_cfg.latch   = latch;
        o_cfg.divisor = divisor;
        o_cfg.oneshot = ctrl.oneshot;
    end

    assign o_irq_pending = irq_pending;

endmodule

/* timer_tb.sv */
`timescale 1ns/1ps

module timer_tb;

    localparam int NUM_CHANNELS  = 2;
    localparam int PRESCALE_BITS = 2;

    typedef enum logic [2:0] {
        OP_WRITE,
        OP_READ,
        OP_READ_MAX,
        OP_WAIT,
        OP_IRQB
    } op_e;

    // for waits the data field holds the cycle count
    typedef struct packed {
        op_e                  op;
        logic [3:0]           test;
        logic                 ch;
        timer_pkg::reg_addr_e offset;
        logic [7:0]           data;
        logic [7:0]           exp;
    } row_t;

    logic        clk;
    logic        reset;
    logic        i_cs;
    logic        i_rwb;
    logic [2:0]  i_addr;
    logic [7:0]  i_data;
    logic [7:0]  o_data;
    logic        o_irqb;
    row_t        stim_q[$];
    logic [15:0] lfsr_state;
    int          cycles;
    int          cycle_limit;
    int          test_errs;
    int          tests_passed;
    int          tests_failed;

    tb_clock_gen #(
        .HALF_PERIOD  (10),
        .RESET_CYCLES (10)
    ) u_clk (
        .o_clk   (clk),
        .o_reset (reset)
    );

    timer_top #(
        .NUM_CHANNELS  (NUM_CHANNELS),
        .PRESCALE_BITS (PRESCALE_BITS)
    ) uut (
        .clk    (clk),
        .reset  (reset),
        .i_cs   (i_cs),
        .i_rwb  (i_rwb),
        .i_addr (i_addr),
        .i_data (i_data),
        .o_data (o_data),
        .o_irqb (o_irqb)
    );

    // galois form with taps x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 16'hB400;
        end
        return s >> 1;
    endfunction

    // one step per bit taken
    function automatic logic [7:0] lfsr_byte();
        logic [7:0] b;
        b = '0;
        for (int i = 0; i < 8; i++) begin
            b          = {lfsr_state[0], b[7:1]};
            lfsr_state = lfsr_next(lfsr_state);
        end
        return b;
    endfunction

    task automatic add_row(input op_e op, input int test, input int ch,
                           input timer_pkg::reg_addr_e offset, input int data, input int exp);
        row_t r;
        r.op     = op;
        r.test   = 4'(test);
        r.ch     = 1'(ch);
        r.offset = offset;
        r.data   = 8'(data);
        r.exp    = 8'(exp);
        stim_q.push_back(r);
    endtask

    // latch low goes last since it starts the channel
    task automatic add_setup(input int test, input int ch, input int ctrl, input int div,
                             input int latch);
        add_row(OP_WRITE, test, ch, timer_pkg::REG_DIV, div, 0);
        add_row(OP_WRITE, test, ch, timer_pkg::REG_CTRL_STAT, ctrl, 0);
        add_row(OP_WRITE, test, ch, timer_pkg::REG_HI, latch >> 8, 0);
        add_row(OP_WRITE, test, ch, timer_pkg::REG_LO, latch & 255, 0);
    endtask

    task automatic build_stim();
        logic [7:0] div_val [2];
        logic [7:0] ctrl_val;
        int         period;
        for (int ch = 0; ch < 2; ch++) begin
            add_row(OP_READ, 1, ch, timer_pkg::REG_DIV, 0, 0);
            add_row(OP_READ, 1, ch, timer_pkg::REG_CTRL_STAT, 0, 0);
            add_row(OP_READ, 1, ch, timer_pkg::REG_LO, 0, 0);
            add_row(OP_READ, 1, ch, timer_pkg::REG_HI, 0, 0);
        end
        add_row(OP_IRQB, 1, 0, timer_pkg::REG_LO, 0, 1);
        for (int ch = 0; ch < 2; ch++) begin
            div_val[ch] = lfsr_byte();
            ctrl_val    = lfsr_byte();
            add_row(OP_WRITE, 2, ch, timer_pkg::REG_DIV, div_val[ch], 0);
            add_row(OP_WRITE, 2, ch, timer_pkg::REG_CTRL_STAT, ctrl_val, 0);
        end
        // stopped channels show neither running nor pending whatever the control byte
        for (int ch = 0; ch < 2; ch++) begin
            add_row(OP_READ, 2, ch, timer_pkg::REG_DIV, 0, div_val[ch]);
            add_row(OP_READ, 2, ch, timer_pkg::REG_CTRL_STAT, 0, 0);
        end
        period = (3 + 1) * (1 + 1) * (1 << PRESCALE_BITS);
        add_setup(3, 0, 1, 1, 3);
        add_row(OP_WAIT, 3, 0, timer_pkg::REG_LO, period - 1, 0);
        add_row(OP_IRQB, 3, 0, timer_pkg::REG_LO, 0, 1);
        add_row(OP_WAIT, 3, 0, timer_pkg::REG_LO, 1, 0);
        add_row(OP_IRQB, 3, 0, timer_pkg::REG_LO, 0, 0);
        add_row(OP_READ, 3, 0, timer_pkg::REG_CTRL_STAT, 0, 3);
        add_row(OP_IRQB, 3, 0, timer_pkg::REG_LO, 0, 1);
        // last check sat 36 cycles after start so the next one lands just before the second match
        add_row(OP_WAIT, 3, 0, timer_pkg::REG_LO, 2 * period - 37, 0);
        add_row(OP_IRQB, 3, 0, timer_pkg::REG_LO, 0, 1);
        add_row(OP_IRQB, 3, 0, timer_pkg::REG_LO, 0, 0);
        // clear and mute channel 0
        add_row(OP_READ, 3, 0, timer_pkg::REG_CTRL_STAT, 0, 3);
        add_row(OP_WRITE, 3, 0, timer_pkg::REG_CTRL_STAT, 0, 0);
        add_row(OP_IRQB, 3, 0, timer_pkg::REG_LO, 0, 1);
        // one-shot match after 12 cycles
        add_setup(4, 1, 3, 0, 2);
        add_row(OP_WAIT, 4, 1, timer_pkg::REG_LO, 20, 0);
        add_row(OP_IRQB, 4, 1, timer_pkg::REG_LO, 0, 0);
        add_row(OP_READ, 4, 1, timer_pkg::REG_CTRL_STAT, 0, 2);
        add_row(OP_READ, 4, 1, timer_pkg::REG_LO, 0, 2);
        add_row(OP_READ, 4, 1, timer_pkg::REG_HI, 0, 0);
        add_row(OP_WAIT, 4, 1, timer_pkg::REG_LO, 16, 0);
        add_row(OP_READ, 4, 1, timer_pkg::REG_LO, 0, 2);
        add_row(OP_READ, 4, 1, timer_pkg::REG_CTRL_STAT, 0, 0);
        add_row(OP_IRQB, 4, 1, timer_pkg::REG_LO, 0, 1);
        // period 16 with reads 19 cycles apart so they fall at several phases
        add_setup(5, 0, 0, 0, 3);
        for (int k = 0; k < 5; k++) begin
            add_row(OP_WAIT, 5, 0, timer_pkg::REG_LO, 16, 0);
            add_row(OP_READ_MAX, 5, 0, timer_pkg::REG_LO, 0, 3);
            add_row(OP_READ, 5, 0, timer_pkg::REG_CTRL_STAT, 0, 1);
            add_row(OP_IRQB, 5, 0, timer_pkg::REG_LO, 0, 1);
        end
        add_row(OP_WRITE, 6, 0, timer_pkg::REG_CTRL_STAT, 3, 0);
        add_row(OP_WRITE, 6, 0, timer_pkg::REG_LO, 1, 0);
        add_row(OP_WRITE, 6, 1, timer_pkg::REG_LO, 1, 0);
        add_row(OP_WAIT, 6, 0, timer_pkg::REG_LO, 20, 0);
        add_row(OP_IRQB, 6, 0, timer_pkg::REG_LO, 0, 0);
        add_row(OP_READ, 6, 0, timer_pkg::REG_CTRL_STAT, 0, 2);
        add_row(OP_IRQB, 6, 0, timer_pkg::REG_LO, 0, 0);
        add_row(OP_READ, 6, 1, timer_pkg::REG_CTRL_STAT, 0, 2);
        add_row(OP_IRQB, 6, 0, timer_pkg::REG_LO, 0, 1);
    endtask

    task automatic bus_write(input row_t r);
        @(negedge clk);
        i_cs   = 1'b1;
        i_rwb  = 1'b0;
        i_addr = {r.ch, r.offset};
        i_data = r.data;
    endtask

    // o_data settles well before the rising edge that may clear a flag
    task automatic bus_read(input row_t r, output logic [7:0] got);
        @(negedge clk);
        i_cs   = 1'b1;
        i_rwb  = 1'b1;
        i_addr = {r.ch, r.offset};
        #5;
        got = o_data;
    endtask

    task automatic idle_cycles(input int n);
        @(negedge clk);
        i_cs = 1'b0;
        repeat (n - 1) @(negedge clk);
    endtask

    task automatic run_row(input row_t r);
        logic [7:0] got;
        case (r.op)
            OP_WRITE: bus_write(r);
            OP_READ: begin
                bus_read(r, got);
                assert (got == r.exp) else begin
                    $display("CHECK FAILED at %0t: ch %0d offset %0d read %02h, expected %02h",
                             $time, r.ch, r.offset, got, r.exp);
                    test_errs++;
                end
            end
            OP_READ_MAX: begin
                bus_read(r, got);
                assert (got <= r.exp) else begin
                    $display("CHECK FAILED at %0t: ch %0d offset %0d read %02h, above %02h",
                             $time, r.ch, r.offset, got, r.exp);
                    test_errs++;
                end
            end
            OP_WAIT: idle_cycles(int'(r.data));
            OP_IRQB: begin
                idle_cycles(1);
                #5;
                assert (o_irqb == r.exp[0]) else begin
                    $display("CHECK FAILED at %0t: irqb is %0b, expected %0b",
                             $time, o_irqb, r.exp[0]);
                    test_errs++;
                end
            end
        endcase
    endtask

    task automatic report_test(input int test);
        if (test_errs == 0) begin
            $display("test %0d passed", test);
            tests_passed++;
        end else begin
            $display("test %0d failed with %0d errors", test, test_errs);
            tests_failed++;
        end
        test_errs = 0;
    endtask

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycle_limit > 0 && cycles > cycle_limit) begin
            $display("timeout: the tests did not finish within %0d cycles", cycle_limit);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    initial begin
        int wait_sum;
        int bus_rows;
        i_cs         = 1'b0;
        i_rwb        = 1'b1;
        i_addr       = '0;
        i_data       = '0;
        cycles       = 0;
        cycle_limit  = 0;
        test_errs    = 0;
        tests_passed = 0;
        tests_failed = 0;
        wait_sum     = 0;
        bus_rows     = 0;
        // seed
        lfsr_state   = 16'd30;
        build_stim();
        foreach (stim_q[i]) begin
            if (stim_q[i].op == OP_WAIT) begin
                wait_sum += int'(stim_q[i].data);
            end else begin
                bus_rows++;
            end
        end
        cycle_limit = 2 * (wait_sum + bus_rows);
        wait (reset == 1'b0);
        for (int i = 0; i < stim_q.size(); i++) begin
            run_row(stim_q[i]);
            if (i == stim_q.size() - 1 || stim_q[i + 1].test != stim_q[i].test) begin
                report_test(int'(stim_q[i].test));
            end
        end
        $display("summary: %0d tests passed, %0d tests failed", tests_passed, tests_failed);
        if (tests_failed == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

/* timer_top.sv */
`timescale 1ns/1ps

module timer_top #(
    parameter int NUM_CHANNELS  = 2,
    parameter int PRESCALE_BITS = 8,
    parameter int CH_W          = (NUM_CHANNELS > 1) ? $clog2(NUM_CHANNELS) : 1
) (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          i_cs,
    input  logic                          i_rwb,
    input  logic [CH_W+1:0]               i_addr,
    input  logic [timer_pkg::DATA_W-1:0]  i_data,
    output logic [timer_pkg::DATA_W-1:0]  o_data,
    output logic                          o_irqb
);

    timer_pkg::bus_req_t          req [NUM_CHANNELS];
    logic [timer_pkg::DATA_W-1:0] rdata [NUM_CHANNELS];
    logic [NUM_CHANNELS-1:0]      irq_pending;
    timer_pkg::chan_cfg_t         cfg [NUM_CHANNELS];
    timer_pkg::chan_stat_t        stat [NUM_CHANNELS];
    logic [NUM_CHANNELS-1:0]      tick;

    timer_bus #(
        .NUM_CHANNELS (NUM_CHANNELS),
        .CH_W         (CH_W)
    ) u_bus (
        .i_cs          (i_cs),
        .i_rwb         (i_rwb),
        .i_addr        (i_addr),
        .i_data        (i_data),
        .o_req         (req),
        .i_rdata       (rdata),
        .i_irq_pending (irq_pending),
        .o_data        (o_data),
        .o_irqb        (o_irqb)
    );

    // one register block and datapath per channel
    for (genvar ch = 0; ch < NUM_CHANNELS; ch++) begin : g_chan
        timer_regs u_regs (
            .clk           (clk),
            .reset         (reset),
            .i_req         (req[ch]),
            .i_stat        (stat[ch]),
            .o_cfg         (cfg[ch]),
            .o_rdata       (rdata[ch]),
            .o_irq_pending (irq_pending[ch])
        );

        timer_prescaler #(
            .PRESCALE_BITS (PRESCALE_BITS)
        ) u_prescaler (
            .clk    (clk),
            .reset  (reset),
            .i_cfg  (cfg[ch]),
            .o_tick (tick[ch])
        );

        timer_counter u_counter (
            .clk    (clk),
            .reset  (reset),
            .i_cfg  (cfg[ch]),
            .i_tick (tick[ch]),
            .o_stat (stat[ch])
        );
    end

endmodule
